// File: source/core_pkg.sv
/* rv32i pipeline definitions */
package core_pkg;

    // data and address widths
    localparam int xlen = 32;
    localparam int instr_addr_width = 12;
    localparam int reg_addr_width = 5;
    localparam logic [xlen-1:0] reset_pc = '0;

    // major opcodes of the supported subset
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal = 7'b1101111;

    // function fields
    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_slt = 3'b010;
    localparam logic [2:0] funct3_sltu = 3'b011;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;
    localparam logic [2:0] funct3_beq = 3'b000;
    localparam logic [2:0] funct3_bne = 3'b001;
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt = 7'b0100000;

    typedef enum logic [3:0] {
        op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu,
        op_addi, op_lui, op_beq, op_bne, op_jal, op_invalid
    } op_t;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0] funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0] opcode;
    } r_form_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0] funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0] opcode;
    } i_form_t;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10_5;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic imm11;
        logic [6:0] opcode;
    } b_form_t;

    // upper 20 bits in this order also form the u immediate
    typedef struct packed {
        logic imm20;
        logic [9:0] imm10_1;
        logic imm11;
        logic [7:0] imm19_12;
        logic [reg_addr_width-1:0] rd;
        logic [6:0] opcode;
    } j_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
        b_form_t b_form;
        j_form_t j_form;
    } instr_word_t;

    // fetch to decode
    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        instr_word_t word;
    } fetch_t;

    // decode to execute
    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        op_t op;
        logic [reg_addr_width-1:0] rd;
        logic write_enable;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        logic [xlen-1:0] immediate;
    } decoded_t;

    // execute to write back, also the retire report
    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic [reg_addr_width-1:0] rd;
        logic write_enable;
        logic [xlen-1:0] value;
    } result_t;

    typedef struct packed {
        logic taken;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

// File: source/fetch_stage.sv
/* instruction fetch */
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  redirect_t redirect,
    input  logic [xlen-1:0] instr_read_data,
    output logic [instr_addr_width-1:0] instr_address,
    output logic instr_read_enable,
    output fetch_t fetch
);

    // byte address presented to memory this cycle
    logic [xlen-1:0] pc;
    // address presented last cycle, its word arrives now
    logic [xlen-1:0] issued_pc;
    logic issued_valid;

    // memory is word addressed
    assign instr_address = pc[instr_addr_width+1:2];
    // one read every cycle, nothing ever stalls
    assign instr_read_enable = 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
            issued_valid <= 1'b0;
        end else begin
            // taken branch in execute overrides the sequential step
            pc <= redirect.taken ? redirect.target : pc + xlen'(4);
            // the read in flight on a redirect is on the wrong path
            issued_valid <= !redirect.taken;
        end
    end

    always_ff @(posedge clock) begin
        issued_pc <= pc;
        // pair the returned word with the address it was read from
        fetch.pc <= issued_pc;
        fetch.word <= instr_read_data;
        if (reset || redirect.taken) begin
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= issued_valid;
        end
    end

    // misaligned redirect targets would show up here
    assert property (@(posedge clock) disable iff (reset) pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned: %h", pc);

endmodule

// File: source/register_file.sv
/* integer register file */
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic clock,
    input  logic [reg_addr_width-1:0] read_index_1,
    input  logic [reg_addr_width-1:0] read_index_2,
    output logic [xlen-1:0] read_value_1,
    output logic [xlen-1:0] read_value_2,
    input  result_t write
);

    logic [xlen-1:0] registers [2**reg_addr_width];

    // x0 reads as zero whatever the array holds
    assign read_value_1 = (read_index_1 == '0) ? '0 : registers[read_index_1];
    assign read_value_2 = (read_index_2 == '0) ? '0 : registers[read_index_2];

    // write back at the end of the retire cycle
    always_ff @(posedge clock) begin
        if (write.valid && write.write_enable && write.rd != '0) begin
            registers[write.rd] <= write.value;
        end
    end

    // a write shows on a read of the same index one cycle later
    assert property (@(posedge clock)
        $past(write.valid && write.write_enable && write.rd != '0) &&
        read_index_1 == $past(write.rd) |-> read_value_1 == $past(write.value))
        else $error("register write not visible on the next read");

endmodule

// File: source/decode_stage.sv
/* instruction decode and operand read */
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  fetch_t fetch,
    input  redirect_t redirect,
    input  result_t ex_forward,
    input  result_t wb_forward,
    output decoded_t decoded
);

    logic [xlen-1:0] file_rs1;
    logic [xlen-1:0] file_rs2;
    decoded_t decode_next;

    // rs1 and rs2 sit at the same bits in every format that uses them
    register_file register_file_i (
        .clock        (clock),
        .read_index_1 (fetch.word.r_form.rs1),
        .read_index_2 (fetch.word.r_form.rs2),
        .read_value_1 (file_rs1),
        .read_value_2 (file_rs2),
        .write        (wb_forward)
    );

    // newest producer wins: execute, then write back, then the file
    function automatic logic [xlen-1:0] forward_operand(
        input logic [reg_addr_width-1:0] index,
        input logic [xlen-1:0] file_value,
        input result_t ex_item,
        input result_t wb_item
    );
        if (index == '0) begin
            return '0;
        end
        if (ex_item.valid && ex_item.write_enable && ex_item.rd == index) begin
            return ex_item.value;
        end
        if (wb_item.valid && wb_item.write_enable && wb_item.rd == index) begin
            return wb_item.value;
        end
        return file_value;
    endfunction

    always_comb begin
        decode_next.valid = fetch.valid;
        decode_next.pc = fetch.pc;
        decode_next.rd = fetch.word.r_form.rd;
        decode_next.rs1_value = forward_operand(fetch.word.r_form.rs1, file_rs1,
                                                ex_forward, wb_forward);
        decode_next.rs2_value = forward_operand(fetch.word.r_form.rs2, file_rs2,
                                                ex_forward, wb_forward);
        // i form immediate unless the format says otherwise
        decode_next.immediate = xlen'($signed(fetch.word.i_form.imm));
        decode_next.op = op_invalid;

        case (fetch.word.r_form.opcode)
            opcode_op: begin
                if (fetch.word.r_form.funct7 == funct7_base) begin
                    case (fetch.word.r_form.funct3)
                        funct3_add: decode_next.op = op_add;
                        funct3_slt: decode_next.op = op_slt;
                        funct3_sltu: decode_next.op = op_sltu;
                        funct3_xor: decode_next.op = op_xor;
                        funct3_or: decode_next.op = op_or;
                        funct3_and: decode_next.op = op_and;
                        default: decode_next.op = op_invalid;
                    endcase
                end else if (fetch.word.r_form.funct7 == funct7_alt &&
                             fetch.word.r_form.funct3 == funct3_add) begin
                    decode_next.op = op_sub;
                end
            end
            opcode_op_imm: begin
                // only addi from the immediate group
                if (fetch.word.i_form.funct3 == funct3_add) begin
                    decode_next.op = op_addi;
                end
            end
            opcode_lui: begin
                decode_next.op = op_lui;
                decode_next.immediate = {fetch.word.j_form[31:12], 12'b0};
            end
            opcode_branch: begin
                if (fetch.word.b_form.funct3 == funct3_beq) begin
                    decode_next.op = op_beq;
                end else if (fetch.word.b_form.funct3 == funct3_bne) begin
                    decode_next.op = op_bne;
                end
                decode_next.immediate = xlen'($signed({
                    fetch.word.b_form.imm12, fetch.word.b_form.imm11,
                    fetch.word.b_form.imm10_5, fetch.word.b_form.imm4_1, 1'b0}));
            end
            opcode_jal: begin
                decode_next.op = op_jal;
                decode_next.immediate = xlen'($signed({
                    fetch.word.j_form.imm20, fetch.word.j_form.imm19_12,
                    fetch.word.j_form.imm11, fetch.word.j_form.imm10_1, 1'b0}));
            end
            default: decode_next.op = op_invalid;
        endcase

        // branches and unknown words write nothing
        decode_next.write_enable = !(decode_next.op inside {op_beq, op_bne, op_invalid});
    end

    always_ff @(posedge clock) begin
        decoded <= decode_next;
        // the item behind a taken branch is squashed here
        if (reset || redirect.taken) begin
            decoded.valid <= 1'b0;
        end
    end

endmodule

// File: source/execute_stage.sv
/* execute, branch resolve and result register */
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  decoded_t decoded,
    output redirect_t redirect,
    output result_t ex_forward,
    output result_t result
);

    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_value;
    logic operands_equal;

    // addi takes its second operand from the immediate
    assign operand_b = (decoded.op == op_addi) ? decoded.immediate : decoded.rs2_value;
    assign operands_equal = decoded.rs1_value == decoded.rs2_value;

    always_comb begin
        case (decoded.op)
            op_add, op_addi: alu_value = decoded.rs1_value + operand_b;
            op_sub: alu_value = decoded.rs1_value - operand_b;
            op_and: alu_value = decoded.rs1_value & operand_b;
            op_or: alu_value = decoded.rs1_value | operand_b;
            op_xor: alu_value = decoded.rs1_value ^ operand_b;
            op_slt: alu_value = xlen'($signed(decoded.rs1_value) < $signed(operand_b));
            op_sltu: alu_value = xlen'(decoded.rs1_value < operand_b);
            op_lui: alu_value = decoded.immediate;
            // link address
            op_jal: alu_value = decoded.pc + xlen'(4);
            // branches report zero
            default: alu_value = '0;
        endcase
    end

    // jal is always taken, compare branches only on their condition
    always_comb begin
        redirect.taken = decoded.valid && (decoded.op == op_jal ||
                         (decoded.op == op_beq && operands_equal) ||
                         (decoded.op == op_bne && !operands_equal));
        redirect.target = decoded.pc + decoded.immediate;
    end

    // same item feeds decode forwarding this cycle
    always_comb begin
        ex_forward.valid = decoded.valid && decoded.op != op_invalid;
        ex_forward.pc = decoded.pc;
        ex_forward.rd = decoded.rd;
        ex_forward.write_enable = decoded.write_enable;
        ex_forward.value = alu_value;
    end

    always_ff @(posedge clock) begin
        result <= ex_forward;
        if (reset) begin
            result.valid <= 1'b0;
        end
    end

    // decode drops the item behind a taken branch
    assert property (@(posedge clock) disable iff (reset)
        redirect.taken |=> !decoded.valid)
        else $error("item behind a taken branch not squashed");

endmodule

// File: source/rv_core.sv
/* four stage rv32i core */
`timescale 1ns/1ps

module rv_core import core_pkg::*; (
    input  logic clock,
    input  logic reset,

    // instruction memory, one cycle read latency
    output logic [instr_addr_width-1:0] instr_address,
    output logic instr_read_enable,
    input  logic [xlen-1:0] instr_read_data,

    // one report per completed instruction
    output result_t retire
);

    fetch_t fetch;
    decoded_t decoded;
    result_t ex_forward;
    result_t result;
    redirect_t redirect;

    fetch_stage fetch_stage_i (
        .clock             (clock),
        .reset             (reset),
        .redirect          (redirect),
        .instr_read_data   (instr_read_data),
        .instr_address     (instr_address),
        .instr_read_enable (instr_read_enable),
        .fetch             (fetch)
    );

    // write back happens inside decode through its register file
    decode_stage decode_stage_i (
        .clock      (clock),
        .reset      (reset),
        .fetch      (fetch),
        .redirect   (redirect),
        .ex_forward (ex_forward),
        .wb_forward (result),
        .decoded    (decoded)
    );

    execute_stage execute_stage_i (
        .clock      (clock),
        .reset      (reset),
        .decoded    (decoded),
        .redirect   (redirect),
        .ex_forward (ex_forward),
        .result     (result)
    );

    // the write back item is what retires
    assign retire = result;

endmodule

// File: test/core_tests.svh
/* directed core tests */

// first retire comes from the reset address
task automatic test_reset();
    program_words.delete();
    program_words.push_back(enc_addi(1, 0, 5));
    program_words.push_back(enc_addi(2, 1, 3));
    run_program("reset");
endtask

// each instruction uses a result one or two slots back
task automatic test_alu_forwarding();
    program_words.delete();
    program_words.push_back(enc_addi(1, 0, 100));
    program_words.push_back(enc_lui(2, 20'h12345));
    program_words.push_back(enc_r(funct7_base, 2, 1, funct3_add, 3));
    program_words.push_back(enc_r(funct7_alt, 1, 3, funct3_add, 4));
    program_words.push_back(enc_r(funct7_base, 3, 4, funct3_and, 5));
    program_words.push_back(enc_r(funct7_base, 1, 5, funct3_or, 6));
    program_words.push_back(enc_r(funct7_base, 4, 6, funct3_xor, 7));
    program_words.push_back(enc_addi(8, 0, -7));
    program_words.push_back(enc_r(funct7_base, 1, 8, funct3_slt, 9));
    program_words.push_back(enc_r(funct7_base, 1, 8, funct3_sltu, 10));
    program_words.push_back(enc_r(funct7_base, 9, 10, funct3_add, 11));
    run_program("alu_forwarding");
endtask

// taken and not taken beq and bne
task automatic test_branches();
    program_words.delete();
    program_words.push_back(enc_addi(1, 0, 3));
    program_words.push_back(enc_addi(2, 0, 3));
    program_words.push_back(enc_branch(funct3_beq, 1, 2, 12));
    program_words.push_back(enc_addi(3, 0, 1));
    program_words.push_back(enc_addi(3, 0, 2));
    program_words.push_back(enc_branch(funct3_bne, 1, 2, 12));
    program_words.push_back(enc_addi(5, 0, 9));
    program_words.push_back(enc_branch(funct3_bne, 5, 1, 8));
    program_words.push_back(enc_addi(6, 0, 4));
    program_words.push_back(enc_addi(7, 0, 1));
    program_words.push_back(enc_branch(funct3_beq, 7, 0, 8));
    program_words.push_back(enc_addi(8, 7, 1));
    run_program("branches");
endtask

// link value, jump target and writes aimed at x0
task automatic test_jal();
    program_words.delete();
    program_words.push_back(enc_addi(1, 0, 1));
    program_words.push_back(enc_jal(5, 12));
    program_words.push_back(enc_addi(2, 0, 2));
    program_words.push_back(enc_addi(3, 0, 3));
    program_words.push_back(enc_addi(6, 5, 4));
    program_words.push_back(enc_jal(0, 12));
    program_words.push_back(enc_addi(7, 0, 7));
    program_words.push_back(enc_addi(7, 0, 8));
    program_words.push_back(enc_r(funct7_base, 0, 6, funct3_add, 8));
    // x0 read right behind a retiring write to x0
    program_words.push_back(enc_addi(0, 0, 5));
    program_words.push_back(enc_r(funct7_base, 0, 0, funct3_add, 9));
    run_program("jal");
endtask

// unknown opcodes sit between live instructions
task automatic test_invalid_words();
    program_words.delete();
    program_words.push_back(enc_addi(1, 0, 7));
    program_words.push_back(32'hffff_ffff);
    program_words.push_back(enc_addi(2, 1, 1));
    program_words.push_back(32'h0000_1000);
    program_words.push_back(enc_r(funct7_base, 1, 2, funct3_add, 3));
    run_program("invalid_words");
endtask

// File: test/core_tb.sv
/* rv32i core testbench */
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    localparam int reset_cycles = 10;
    localparam int retire_timeout = 40;
    localparam int idle_cycles = 30;
    localparam int memory_words = 2**instr_addr_width;

    logic clock;
    logic reset;
    logic [instr_addr_width-1:0] instr_address;
    logic instr_read_enable;
    logic [xlen-1:0] instr_read_data;
    result_t retire;

    logic [xlen-1:0] imem [memory_words];
    logic [xlen-1:0] program_words [$];
    // expected retire list built by the reference model
    logic [xlen-1:0] expected_pc [$];
    logic [reg_addr_width-1:0] expected_rd [$];
    logic expected_write [$];
    logic [xlen-1:0] expected_value [$];
    int error_count;

    rv_core rv_core_i (
        .clock             (clock),
        .reset             (reset),
        .instr_address     (instr_address),
        .instr_read_enable (instr_read_enable),
        .instr_read_data   (instr_read_data),
        .retire            (retire)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // one cycle read latency, word ready after the edge
    always @(posedge clock) begin
        instr_read_data <= imem[instr_address];
    end

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opcode_op};
    endfunction

    function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), funct3_add, 5'(rd), opcode_op_imm};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input logic [19:0] upper);
        return {upper, 5'(rd), opcode_lui};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input int rs1,
                                               input int rs2, input int offset);
        logic [12:0] imm;
        imm = 13'(offset);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], opcode_branch};
    endfunction

    function automatic logic [31:0] enc_jal(input int rd, input int offset);
        logic [20:0] imm;
        imm = 21'(offset);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), opcode_jal};
    endfunction

    // program at word 0, every other word an unknown opcode tagged with its address
    task automatic load_program();
        for (int a = 0; a < memory_words; a++) begin
            imem[a] = {13'h0, 12'(a), 7'b0000000};
        end
        foreach (program_words[i]) begin
            imem[i] = program_words[i];
        end
    endtask

    // instruction set model, walks the program and records every retire
    task automatic build_expected();
        logic [xlen-1:0] regs [32];
        logic [xlen-1:0] pc;
        logic [31:0] w;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] v;
        logic [xlen-1:0] next_pc;
        logic known;
        logic writes;
        int steps;
        expected_pc.delete();
        expected_rd.delete();
        expected_write.delete();
        expected_value.delete();
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc = reset_pc;
        steps = 0;
        while (pc < 4 * program_words.size() && steps < 200) begin
            w = imem[pc[instr_addr_width+1:2]];
            a = regs[w[19:15]];
            b = regs[w[24:20]];
            next_pc = pc + 4;
            known = 1'b1;
            writes = 1'b1;
            v = '0;
            case (w[6:0])
                7'b0110011: begin
                    case ({w[31:25], w[14:12]})
                        10'b0000000_000: v = a + b;
                        10'b0100000_000: v = a - b;
                        10'b0000000_111: v = a & b;
                        10'b0000000_110: v = a | b;
                        10'b0000000_100: v = a ^ b;
                        10'b0000000_010: v = {31'b0, $signed(a) < $signed(b)};
                        10'b0000000_011: v = {31'b0, a < b};
                        default: known = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    known = (w[14:12] == 3'b000);
                    v = a + {{20{w[31]}}, w[31:20]};
                end
                7'b0110111: v = {w[31:12], 12'b0};
                7'b1100011: begin
                    writes = 1'b0;
                    known = (w[14:12] == 3'b000 || w[14:12] == 3'b001);
                    if ((w[14:12] == 3'b000) == (a == b)) begin
                        next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    v = pc + 4;
                    next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                default: known = 1'b0;
            endcase
            if (known) begin
                expected_pc.push_back(pc);
                expected_rd.push_back(w[11:7]);
                expected_write.push_back(writes);
                expected_value.push_back(v);
                if (writes && w[11:7] != 0) begin
                    regs[w[11:7]] = v;
                end
                pc = next_pc;
            end else begin
                pc = pc + 4;
            end
            steps++;
        end
    endtask

    // reset is high for the set number of cycles, checked after the first edge
    task automatic pulse_reset();
        @(posedge clock);
        reset <= 1'b1;
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clock);
            if (i > 0 && retire.valid !== 1'b0) begin
                error_count++;
                $display("ERROR %0t: retire.valid expected 0 got %b", $time, retire.valid);
            end
            if (i > 0 && instr_address !== '0) begin
                error_count++;
                $display("ERROR %0t: instr_address expected 0 got %h", $time, instr_address);
            end
            if (instr_read_enable !== 1'b1) begin
                error_count++;
                $display("ERROR %0t: instr_read_enable expected 1 got %b",
                         $time, instr_read_enable);
            end
            @(posedge clock);
        end
        reset <= 1'b0;
        // first cycle out of reset still presents the reset address
        @(negedge clock);
        if (instr_address !== '0) begin
            error_count++;
            $display("ERROR %0t: instr_address expected 0 got %h", $time, instr_address);
        end
        if (retire.valid !== 1'b0) begin
            error_count++;
            $display("ERROR %0t: retire.valid expected 0 got %b", $time, retire.valid);
        end
        if (instr_read_enable !== 1'b1) begin
            error_count++;
            $display("ERROR %0t: instr_read_enable expected 1 got %b",
                     $time, instr_read_enable);
        end
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // compare every retire in order, then watch for stray ones
    task automatic check_retires(input string test_name);
        int waited;
        for (int i = 0; i < expected_pc.size(); i++) begin
            waited = 0;
            if (i > 0) begin
                @(negedge clock);
            end
            while (retire.valid !== 1'b1 && waited < retire_timeout) begin
                @(negedge clock);
                waited++;
            end
            if (retire.valid !== 1'b1) begin
                error_count++;
                $display("%s: timed out waiting for the retire of pc %h",
                         test_name, expected_pc[i]);
                return;
            end
            check_value("retire.pc", expected_pc[i], retire.pc);
            check_value("retire.write_enable", xlen'(expected_write[i]),
                        xlen'(retire.write_enable));
            if (expected_write[i]) begin
                check_value("retire.rd", xlen'(expected_rd[i]), xlen'(retire.rd));
                check_value("retire.value", expected_value[i], retire.value);
            end
        end
        for (int c = 0; c < idle_cycles; c++) begin
            @(negedge clock);
            if (retire.valid !== 1'b0) begin
                error_count++;
                $display("%s: unexpected retire of pc %h at %0t", test_name, retire.pc, $time);
            end
        end
    endtask

    task automatic run_program(input string test_name);
        load_program();
        build_expected();
        pulse_reset();
        check_retires(test_name);
        $display("%s done, %0d retires expected", test_name, expected_pc.size());
    endtask

    `include "core_tests.svh"

    initial begin
        reset = 1'b1;
        instr_read_data = '0;
        error_count = 0;
        test_reset();
        test_alu_forwarding();
        test_branches();
        test_jal();
        test_invalid_words();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+test
source/core_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/rv_core.sv
test/core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - source/core_pkg.sv
  - source/fetch_stage.sv
  - source/register_file.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/rv_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/core_tb.sv
